//--- gpio_periph.sv
// gpio controller, zero-delay bus port
// output and enable registers, synchronized input

`timescale 1ns/1ps

module gpio_periph
    import soc_bus_pkg::*;
#(
    parameter int unsigned GPIO_DAT = 32
)(
    input  logic                clk,
    input  logic                reset,
    input  logic                vld,
    input  tcb_req_t            req,
    output logic                rdy,
    output tcb_rsp_t            rsp,
    output logic [GPIO_DAT-1:0] gpio_o,
    output logic [GPIO_DAT-1:0] gpio_e,
    input  logic [GPIO_DAT-1:0] gpio_i
);

    logic [OFS_W-1:0]    ofs;
    logic [GPIO_DAT-1:0] gpio_m;
    logic [GPIO_DAT-1:0] gpio_s;

    assign ofs = req.adr[OFS_W-1:0];

    // full-word writes, gpio_in is read only
    always_ff @(posedge clk) begin
        if (reset) begin
            rdy    <= 1'b0;
            gpio_o <= '0;
            gpio_e <= '0;
        end else begin
            rdy <= 1'b1;
            if (vld & req.wen & (ofs == GPIO_OUT_OFS)) gpio_o <= req.wdt[GPIO_DAT-1:0];
            if (vld & req.wen & (ofs == GPIO_ENA_OFS)) gpio_e <= req.wdt[GPIO_DAT-1:0];
        end
    end

    // two-flop input synchronizer
    always_ff @(posedge clk) begin
        gpio_m <= gpio_i;
        gpio_s <= gpio_m;
    end

    // read mux, error for unknown offsets
    always_comb begin
        rsp = '{rdt: '0, err: 1'b0};
        case (ofs)
            GPIO_OUT_OFS: rsp.rdt = tcb_dat_t'(gpio_o);
            GPIO_ENA_OFS: rsp.rdt = tcb_dat_t'(gpio_e);
            GPIO_IN_OFS:  rsp.rdt = tcb_dat_t'(gpio_s);
            default:      rsp.err = 1'b1;
        endcase
    end

endmodule

//--- run.sh
#!/bin/sh
# build the simulation with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f soc_top.f --top-module soc_top_tb -o soc_top_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/soc_top_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

//--- soc_bus_pkg.sv
// bus widths and vector types
// request and response structs for the system bus
// address map, register offsets, UART FSM state types

package soc_bus_pkg;

    ////////////////////////////////////////////////////////////
    // widths and vector types
    ////////////////////////////////////////////////////////////

    localparam int unsigned XLEN  = 32;
    // low address bits that hold a register offset
    localparam int unsigned OFS_W = 16;

    typedef logic [XLEN-1:0]   tcb_adr_t;
    typedef logic [XLEN-1:0]   tcb_dat_t;
    // log2 of transfer size in bytes
    typedef logic [1:0]        tcb_siz_t;
    typedef logic [XLEN/8-1:0] tcb_ben_t;
    typedef logic [7:0]        uart_byte_t;

    // request, 67 bits
    typedef struct packed {
        logic     wen;
        tcb_adr_t adr;
        tcb_siz_t siz;
        tcb_dat_t wdt;
    } tcb_req_t;

    // response, 33 bits
    typedef struct packed {
        tcb_dat_t rdt;
        logic     err;
    } tcb_rsp_t;

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////

    localparam tcb_adr_t MEM_BASE     = 32'h8000_0000;
    localparam tcb_adr_t PER_BASE     = 32'h8001_0000;
    localparam tcb_adr_t REGION_MASK  = 32'hffff_0000;
    // uart when set, gpio when clear
    localparam int unsigned PER_UART_BIT = 6;

    // gpio registers
    localparam logic [OFS_W-1:0] GPIO_OUT_OFS  = 16'h0000;
    localparam logic [OFS_W-1:0] GPIO_ENA_OFS  = 16'h0004;
    localparam logic [OFS_W-1:0] GPIO_IN_OFS   = 16'h0008;
    // uart registers
    localparam logic [OFS_W-1:0] UART_DATA_OFS = 16'h0040;
    localparam logic [OFS_W-1:0] UART_STAT_OFS = 16'h0044;

    // uart transmitter and receiver states
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} uart_rx_state_t;

endpackage

//--- soc_memory.sv
// data memory with log2 size to byte enable conversion
// byte-masked writes, registered read, misalignment error

`timescale 1ns/1ps

module soc_memory
    import soc_bus_pkg::*;
#(
    parameter int unsigned MEM_ADR = 8
)(
    input  logic     clk,
    input  logic     reset,
    input  logic     vld,
    input  tcb_req_t req,
    output logic     rdy,
    output tcb_rsp_t rsp
);

    tcb_dat_t           mem [2**MEM_ADR];
    tcb_ben_t           ben;
    tcb_dat_t           wdt;
    logic               mis;
    logic [MEM_ADR-1:0] idx;
    tcb_dat_t           rdt_q;
    logic               err_q;

    // memory starts cleared
    initial begin
        for (int i = 0; i < 2**MEM_ADR; i++) begin
            mem[i] = '0;
        end
    end

    // byte lanes from size and low address bits
    always_comb begin
        case (req.siz)
            2'd0:    ben = tcb_ben_t'(4'b0001 << req.adr[1:0]);
            2'd1:    ben = req.adr[1] ? 4'b1100 : 4'b0011;
            default: ben = 4'b1111;
        endcase
    end

    // half on odd byte, word off a word boundary
    assign mis = ((req.siz == 2'd1) & req.adr[0]) | (req.siz[1] & |req.adr[1:0]);
    assign idx = req.adr[MEM_ADR+1:2];
    // write data lsb aligned, moved onto its lanes
    assign wdt = req.wdt << (8 * req.adr[1:0]);

    always_ff @(posedge clk) begin
        if (vld & rdy & req.wen & ~mis) begin
            for (int b = 0; b < XLEN/8; b++) begin
                if (ben[b]) mem[idx][8*b+:8] <= wdt[8*b+:8];
            end
        end
        if (vld & rdy) rdt_q <= mem[idx];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdy   <= 1'b0;
            err_q <= 1'b0;
        end else begin
            rdy   <= 1'b1;
            if (vld & rdy) err_q <= mis;
        end
    end

    assign rsp = '{rdt: rdt_q, err: err_q};

endmodule

//--- soc_top.f
soc_bus_pkg.sv
tcb_bus_demux.sv
tcb_register_request.sv
soc_memory.sv
gpio_periph.sv
uart_periph.sv
soc_top.sv
soc_top_checker.sv
soc_top_tb.sv

//--- soc_top.sv
// system bus side of the microcontroller
// region demux, peripheral register stage and demux
// data memory, gpio and uart controllers

`timescale 1ns/1ps

module soc_top
    import soc_bus_pkg::*;
#(
    parameter int unsigned MEM_ADR  = 8,
    parameter int unsigned GPIO_DAT = 32,
    parameter int unsigned FIFO_SIZ = 4,
    parameter int unsigned UART_BDR = 8
)(
    input  logic                clk,
    input  logic                reset,
    // cpu bus port
    input  logic                tcb_vld,
    input  tcb_req_t            tcb_req,
    output logic                tcb_rdy,
    output tcb_rsp_t            tcb_rsp,
    // gpio pins
    output logic [GPIO_DAT-1:0] gpio_o,
    output logic [GPIO_DAT-1:0] gpio_e,
    input  logic [GPIO_DAT-1:0] gpio_i,
    // uart pins
    output logic                uart_txd,
    input  logic                uart_rxd
);

    // address bit that picks uart over gpio
    localparam tcb_adr_t UART_SEL = tcb_adr_t'(1) << PER_UART_BIT;

    // region demux outputs, 0 memory, 1 peripherals
    logic [1:0] dmx_vld;
    tcb_req_t   dmx_req [2];
    logic [1:0] dmx_rdy;
    tcb_rsp_t   dmx_rsp [2];
    // peripheral bus after the register stage
    logic       pb0_vld;
    tcb_req_t   pb0_req;
    logic       pb0_rdy;
    tcb_rsp_t   pb0_rsp;
    // peripheral demux outputs, 0 gpio, 1 uart
    logic [1:0] per_vld;
    tcb_req_t   per_req [2];
    logic [1:0] per_rdy;
    tcb_rsp_t   per_rsp [2];

    ////////////////////////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////////////////////////

    tcb_bus_demux #(
        .DLY    (1'b1),
        .MATCH0 (MEM_BASE), .MASK0 (REGION_MASK),
        .MATCH1 (PER_BASE), .MASK1 (REGION_MASK)
    ) bus_demux (
        .clk     (clk),      .reset   (reset),
        .sub_vld (tcb_vld),  .sub_req (tcb_req),
        .sub_rdy (tcb_rdy),  .sub_rsp (tcb_rsp),
        .man_vld (dmx_vld),  .man_req (dmx_req),
        .man_rdy (dmx_rdy),  .man_rsp (dmx_rsp)
    );

    // one-cycle cpu bus onto zero-delay peripherals
    tcb_register_request req_reg (
        .clk     (clk),        .reset   (reset),
        .sub_vld (dmx_vld[1]), .sub_req (dmx_req[1]),
        .sub_rdy (dmx_rdy[1]), .sub_rsp (dmx_rsp[1]),
        .man_vld (pb0_vld),    .man_req (pb0_req),
        .man_rdy (pb0_rdy),    .man_rsp (pb0_rsp)
    );

    tcb_bus_demux #(
        .DLY    (1'b0),
        .MATCH0 ('0),       .MASK0 (UART_SEL),
        .MATCH1 (UART_SEL), .MASK1 (UART_SEL)
    ) per_demux (
        .clk     (clk),      .reset   (reset),
        .sub_vld (pb0_vld),  .sub_req (pb0_req),
        .sub_rdy (pb0_rdy),  .sub_rsp (pb0_rsp),
        .man_vld (per_vld),  .man_req (per_req),
        .man_rdy (per_rdy),  .man_rsp (per_rsp)
    );

    ////////////////////////////////////////////////////////////
    // targets
    ////////////////////////////////////////////////////////////

    soc_memory #(.MEM_ADR (MEM_ADR)) mem (
        .clk (clk),        .reset (reset),
        .vld (dmx_vld[0]), .req   (dmx_req[0]),
        .rdy (dmx_rdy[0]), .rsp   (dmx_rsp[0])
    );

    gpio_periph #(.GPIO_DAT (GPIO_DAT)) gpio (
        .clk    (clk),        .reset  (reset),
        .vld    (per_vld[0]), .req    (per_req[0]),
        .rdy    (per_rdy[0]), .rsp    (per_rsp[0]),
        .gpio_o (gpio_o),     .gpio_e (gpio_e),
        .gpio_i (gpio_i)
    );

    uart_periph #(.UART_BDR (UART_BDR), .FIFO_SIZ (FIFO_SIZ)) uart (
        .clk      (clk),        .reset    (reset),
        .vld      (per_vld[1]), .req      (per_req[1]),
        .rdy      (per_rdy[1]), .rsp      (per_rsp[1]),
        .uart_txd (uart_txd),   .uart_rxd (uart_rxd)
    );

endmodule

//--- soc_top_checker.sv
// bound assertions on the top-level bus port
// and the uart transmit line

`timescale 1ns/1ps

module soc_top_checker
    import soc_bus_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     tcb_vld,
    input logic     tcb_rdy,
    input tcb_rsp_t tcb_rsp,
    input logic     uart_txd
);

    // no transfers accepted while in reset
    a_rdy_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> !tcb_rdy)
        else $error("tcb_rdy high during reset");

    // response error flag known in the cycle after a transfer
    a_err_known: assert property (@(posedge clk) disable iff (reset)
        tcb_vld && tcb_rdy |=> !$isunknown(tcb_rsp.err))
        else $error("tcb_rsp.err unknown after transfer");

    // line idles high through reset and the cycle after
    a_txd_idle: assert property (@(posedge clk) $past(reset) |-> uart_txd)
        else $error("uart_txd low around reset");

endmodule

bind soc_top soc_top_checker chk_i (
    .clk (clk), .reset (reset), .tcb_vld (tcb_vld), .tcb_rdy (tcb_rdy),
    .tcb_rsp (tcb_rsp), .uart_txd (uart_txd)
);

//--- soc_top_tb.sv
// testbench acting as the cpu on the system bus side
// lfsr stimulus, reference model of memory, gpio and uart
// bus tasks, response compare process, test sequence

`timescale 1ns/1ps

module soc_top_tb
    import soc_bus_pkg::*;
;

    localparam int       WAIT_MAX  = 50;
    localparam int       POLL_MAX  = 100;
    localparam int       FIFO_SIZ  = 4;
    localparam tcb_adr_t GPIO_OUT  = PER_BASE | tcb_adr_t'(GPIO_OUT_OFS);
    localparam tcb_adr_t GPIO_ENA  = PER_BASE | tcb_adr_t'(GPIO_ENA_OFS);
    localparam tcb_adr_t GPIO_IN   = PER_BASE | tcb_adr_t'(GPIO_IN_OFS);
    localparam tcb_adr_t UART_DATA = PER_BASE | tcb_adr_t'(UART_DATA_OFS);
    localparam tcb_adr_t UART_STAT = PER_BASE | tcb_adr_t'(UART_STAT_OFS);

    logic        clk = 1'b0;
    logic        reset;
    logic        tcb_vld;
    tcb_req_t    tcb_req;
    logic        tcb_rdy;
    tcb_rsp_t    tcb_rsp;
    logic [31:0] gpio_o, gpio_e, gpio_i;
    logic        uart_txd;

    // reference model state
    logic [7:0]  mem_ref [4096];
    tcb_dat_t    gpio_out_ref, gpio_ena_ref, gpio_in_ref;
    logic        uart_busy, ovr_ref, ovr_seen;
    uart_byte_t  rx_ref [$];
    // pending responses for the compare process
    tcb_rsp_t    exp_q [$], act_q [$];
    tcb_dat_t    rmsk_q [$];
    tcb_adr_t    adr_q [$];
    logic [31:0] lfsr = 32'h9d5ff38a;
    int          errors = 0;
    int          timeouts = 0;

    soc_top dut_i (
        .clk (clk), .reset (reset), .tcb_vld (tcb_vld), .tcb_req (tcb_req),
        .tcb_rdy (tcb_rdy), .tcb_rsp (tcb_rsp), .gpio_o (gpio_o), .gpio_e (gpio_e),
        .gpio_i (gpio_i), .uart_txd (uart_txd), .uart_rxd (uart_txd)
    );

    always #10 clk = ~clk;

    // fibonacci lfsr on taps 32 22 2 1
    // one step per bit taken
    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // predicted response of one transfer
    // model state changes as the transfer would change it
    function tcb_rsp_t ref_rsp(input tcb_req_t r);
        tcb_rsp_t    e;
        int          w;
        logic [1:0]  o;
        logic [15:0] ofs;
        e   = '{rdt: '0, err: 1'b0};
        w   = int'(r.adr[9:2]);
        o   = r.adr[1:0];
        ofs = r.adr[15:0];
        if ((r.adr & REGION_MASK) == MEM_BASE) begin
            for (int b = 0; b < 4; b++) e.rdt[8*b+:8] = mem_ref[4*w+b];
            e.err = (r.siz == 2'd1 && o[0]) || (r.siz == 2'd2 && o != 2'd0);
            if (r.wen && !e.err) begin
                for (int b = 0; b < (1 << r.siz); b++) mem_ref[4*w+o+b] = r.wdt[8*b+:8];
            end
        end else if ((r.adr & REGION_MASK) != PER_BASE) begin
            e.err = 1'b1;
        end else if (ofs == GPIO_OUT_OFS) begin
            e.rdt = gpio_out_ref;
            if (r.wen) gpio_out_ref = r.wdt;
        end else if (ofs == GPIO_ENA_OFS) begin
            e.rdt = gpio_ena_ref;
            if (r.wen) gpio_ena_ref = r.wdt;
        end else if (ofs == GPIO_IN_OFS) begin
            e.rdt = gpio_in_ref;
        end else if (ofs == UART_DATA_OFS && r.wen) begin
            // accepted byte comes back into the fifo through the loopback
            e.err = uart_busy;
            if (!uart_busy && rx_ref.size() < FIFO_SIZ) rx_ref.push_back(r.wdt[7:0]);
            else if (!uart_busy) ovr_ref = 1'b1;
            uart_busy = 1'b1;
        end else if (ofs == UART_DATA_OFS) begin
            e.err = rx_ref.size() == 0;
            if (!e.err) e.rdt = tcb_dat_t'(rx_ref.pop_front());
        end else if (ofs == UART_STAT_OFS) begin
            e.rdt = {29'd0, ovr_ref, rx_ref.size() != 0, uart_busy};
            if (!r.wen) ovr_ref = 1'b0;
        end else begin
            e.err = 1'b1;
        end
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // checks and run control
    ////////////////////////////////////////////////////////////

    task check(input string name, input logic [32:0] act, input logic [32:0] exp);
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, act, exp);
        end
    endtask

    task end_run();
        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
        end_run();
    endtask

    // compare each sampled response with its prediction
    always @(negedge clk) begin
        tcb_rsp_t act, exp;
        tcb_dat_t m;
        tcb_adr_t a;
        while (act_q.size() > 0) begin
            act = act_q.pop_front();
            exp = exp_q.pop_front();
            m   = rmsk_q.pop_front();
            a   = adr_q.pop_front();
            if (m != '0) begin
                check($sformatf("tcb_rsp.rdt at %h", a),
                      {1'b0, act.rdt & m}, {1'b0, exp.rdt & m});
            end
            check($sformatf("tcb_rsp.err at %h", a), 33'(act.err), 33'(exp.err));
        end
    end

    ////////////////////////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////////////////////////

    task bus_xfer(input tcb_req_t r, input tcb_dat_t rmsk, output tcb_rsp_t rsp);
        int n;
        n = 0;
        @(posedge clk);
        tcb_vld <= 1'b1;
        tcb_req <= r;
        @(negedge clk);
        while (!tcb_rdy && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!tcb_rdy) begin
            timeout("tcb_rdy");
        end else begin
            @(posedge clk);
            tcb_vld <= 1'b0;
            // response one cycle after the transfer
            @(negedge clk);
            rsp = tcb_rsp;
            exp_q.push_back(ref_rsp(r));
            act_q.push_back(rsp);
            rmsk_q.push_back(rmsk);
            adr_q.push_back(r.adr);
        end
    endtask

    task bus_write(input tcb_adr_t adr, input tcb_siz_t siz, input tcb_dat_t wdt);
        tcb_rsp_t rsp;
        bus_xfer('{wen: 1'b1, adr: adr, siz: siz, wdt: wdt}, '0, rsp);
    endtask

    task bus_read(input tcb_adr_t adr, input tcb_dat_t rmsk, output tcb_rsp_t rsp);
        bus_xfer('{wen: 1'b0, adr: adr, siz: 2'd2, wdt: '0}, rmsk, rsp);
    endtask

    // read uart status until one bit reaches a level
    task poll_stat(input int bit_idx, input logic level);
        tcb_rsp_t rsp;
        int       n;
        n = 0;
        bus_read(UART_STAT, '0, rsp);
        ovr_seen |= rsp.rdt[2];
        while (rsp.rdt[bit_idx] != level && n < POLL_MAX) begin
            bus_read(UART_STAT, '0, rsp);
            ovr_seen |= rsp.rdt[2];
            n++;
        end
        if (rsp.rdt[bit_idx] != level) timeout("uart status bit");
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        tcb_rsp_t    rsp;
        tcb_siz_t    siz;
        logic [1:0]  off;
        logic [9:0]  widx [24];
        uart_byte_t  ch;
        for (int i = 0; i < 4096; i++) mem_ref[i] = 8'h00;
        gpio_out_ref = '0;
        gpio_ena_ref = '0;
        gpio_in_ref  = '0;
        uart_busy    = 1'b0;
        ovr_ref      = 1'b0;
        ovr_seen     = 1'b0;
        reset   = 1'b1;
        tcb_vld = 1'b0;
        tcb_req = '0;
        gpio_i  = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("gpio_o", 33'(gpio_o), 33'h0);
        check("gpio_e", 33'(gpio_e), 33'h0);
        check("uart_txd", 33'(uart_txd), 33'h1);

        // random memory writes of every size then word reads
        for (int i = 0; i < 24; i++) begin
            siz = tcb_siz_t'(rand_bits(2));
            if (siz == 2'd3) siz = 2'd2;
            off = 2'(rand_bits(2));
            if (siz == 2'd1) off[0] = 1'b0;
            if (siz == 2'd2) off = 2'b00;
            widx[i] = 10'(rand_bits(10));
            bus_write(MEM_BASE | tcb_adr_t'({widx[i], off}), siz, rand_bits(32));
        end
        bus_write(MEM_BASE | tcb_adr_t'({widx[0], 2'b01}), 2'd1, rand_bits(32));
        bus_write(MEM_BASE | tcb_adr_t'({widx[1], 2'b10}), 2'd2, rand_bits(32));
        for (int i = 0; i < 24; i++) bus_read(MEM_BASE | tcb_adr_t'({widx[i], 2'b00}), '1, rsp);

        // unmapped region
        bus_read(32'h9000_0000, '1, rsp);
        bus_write(32'h9000_0010, 2'd2, rand_bits(32));

        // gpio
        bus_write(GPIO_OUT, 2'd2, rand_bits(32));
        bus_write(GPIO_ENA, 2'd2, rand_bits(32));
        @(posedge clk);
        @(negedge clk);
        check("gpio_o", 33'(gpio_o), 33'(gpio_out_ref));
        check("gpio_e", 33'(gpio_e), 33'(gpio_ena_ref));
        bus_read(GPIO_OUT, '1, rsp);
        bus_read(GPIO_ENA, '1, rsp);
        @(posedge clk);
        gpio_in_ref = rand_bits(32);
        gpio_i <= gpio_in_ref;
        repeat (3) @(posedge clk);
        bus_read(GPIO_IN, '1, rsp);
        bus_read(PER_BASE | 32'h0c, '1, rsp);

        // uart loopback with a rejected write while busy
        ch = uart_byte_t'(rand_bits(8));
        bus_write(UART_DATA, 2'd0, tcb_dat_t'(ch));
        bus_read(UART_STAT, 32'h1, rsp);
        bus_write(UART_DATA, 2'd0, rand_bits(32));
        poll_stat(1, 1'b1);
        bus_read(UART_DATA, '1, rsp);
        uart_busy = 1'b0;
        bus_read(UART_STAT, '1, rsp);

        // one byte more than the fifo depth
        // overrun only on the last byte
        for (int k = 0; k <= FIFO_SIZ; k++) begin
            ovr_seen = 1'b0;
            bus_write(UART_DATA, 2'd0, tcb_dat_t'(rand_bits(8)));
            poll_stat(0, 1'b0);
            uart_busy = 1'b0;
            check("uart stat overrun", 33'(ovr_seen), 33'(k == FIFO_SIZ));
        end
        for (int k = 0; k <= FIFO_SIZ; k++) bus_read(UART_DATA, '1, rsp);

        repeat (2) @(negedge clk);
        end_run();
    end

endmodule

//--- tcb_bus_demux.sv
// two-way bus demultiplexer with masked address decoder
// response routed by registered (DLY=1) or live (DLY=0) select
// unmapped transfers are accepted and answered with an error

`timescale 1ns/1ps

module tcb_bus_demux
    import soc_bus_pkg::*;
#(
    parameter bit       DLY    = 1'b1,
    parameter tcb_adr_t MATCH0 = MEM_BASE,
    parameter tcb_adr_t MASK0  = REGION_MASK,
    parameter tcb_adr_t MATCH1 = PER_BASE,
    parameter tcb_adr_t MASK1  = REGION_MASK
)(
    input  logic       clk,
    input  logic       reset,
    // from manager
    input  logic       sub_vld,
    input  tcb_req_t   sub_req,
    output logic       sub_rdy,
    output tcb_rsp_t   sub_rsp,
    // to subordinates
    output logic [1:0] man_vld,
    output tcb_req_t   man_req [2],
    input  logic [1:0] man_rdy,
    input  tcb_rsp_t   man_rsp [2]
);

    ////////////////////////////////////////////////////////////
    // decoder
    ////////////////////////////////////////////////////////////

    logic [1:0] hit;
    logic       sel;
    logic       miss;
    // ready for unmapped requests, low in reset
    logic       acc;

    // output 0 wins on overlap
    assign hit[0] = (sub_req.adr & MASK0) == MATCH0;
    assign hit[1] = ~hit[0] & ((sub_req.adr & MASK1) == MATCH1);
    assign sel    = hit[1];
    assign miss   = ~|hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= 1'b0;
        end else begin
            acc <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // request path
    ////////////////////////////////////////////////////////////

    // vld only toward the matching output
    assign man_vld    = {sub_vld & hit[1], sub_vld & hit[0]};
    assign man_req[0] = sub_req;
    assign man_req[1] = sub_req;
    assign sub_rdy    = miss ? acc : man_rdy[sel];

    ////////////////////////////////////////////////////////////
    // response path
    ////////////////////////////////////////////////////////////

    logic sel_q;
    logic miss_q;
    logic rsp_sel;
    logic rsp_miss;

    // select captured at each transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            sel_q  <= 1'b0;
            miss_q <= 1'b0;
        end else if (sub_vld & sub_rdy) begin
            sel_q  <= sel;
            miss_q <= miss;
        end
    end

    // zero-delay targets use the live select
    assign rsp_sel  = DLY ? sel_q : sel;
    assign rsp_miss = DLY ? miss_q : miss;

    always_comb begin
        if (rsp_miss) begin
            sub_rsp = '{rdt: '0, err: 1'b1};
        end else begin
            sub_rsp = man_rsp[rsp_sel];
        end
    end

endmodule

//--- tcb_register_request.sv
// request register stage between a one-cycle and a zero-delay bus
// captured request replayed one cycle later, response passed back

`timescale 1ns/1ps

module tcb_register_request
    import soc_bus_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    // one-cycle side
    input  logic     sub_vld,
    input  tcb_req_t sub_req,
    output logic     sub_rdy,
    output tcb_rsp_t sub_rsp,
    // zero-delay side
    output logic     man_vld,
    output tcb_req_t man_req,
    input  logic     man_rdy,
    input  tcb_rsp_t man_rsp
);

    // one-cycle vld pulse per accepted transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            man_vld <= 1'b0;
        end else begin
            man_vld <= sub_vld & sub_rdy;
        end
    end

    // request held until the next transfer
    always_ff @(posedge clk) begin
        if (sub_vld & sub_rdy) begin
            man_req <= sub_req;
        end
    end

    // target answers in the replay cycle
    assign sub_rdy = man_rdy;
    assign sub_rsp = man_rsp;

endmodule

//--- uart_periph.sv
// uart controller, zero-delay bus port
// transmitter FSM, oversampled receiver FSM, receive FIFO
// data register and status register

`timescale 1ns/1ps

module uart_periph
    import soc_bus_pkg::*;
#(
    parameter int unsigned UART_BDR = 8,
    parameter int unsigned FIFO_SIZ = 4
)(
    input  logic     clk,
    input  logic     reset,
    input  logic     vld,
    input  tcb_req_t req,
    output logic     rdy,
    output tcb_rsp_t rsp,
    output logic     uart_txd,
    input  logic     uart_rxd
);

    localparam int unsigned    BCW     = $clog2(UART_BDR);
    localparam int unsigned    PTW     = $clog2(FIFO_SIZ);
    localparam int unsigned    CNW     = $clog2(FIFO_SIZ + 1);
    localparam logic [BCW-1:0] BIT_END = BCW'(UART_BDR - 1);
    localparam logic [BCW-1:0] BIT_MID = BCW'(UART_BDR / 2 - 1);

    // circular pointer step
    function automatic logic [PTW-1:0] ptr_inc(input logic [PTW-1:0] ptr);
        return (ptr == PTW'(FIFO_SIZ - 1)) ? '0 : ptr + 1'b1;
    endfunction

    uart_tx_state_t tx_state;
    logic [BCW-1:0] tx_cnt;
    logic [2:0]     tx_bit;
    uart_byte_t     tx_shr;
    uart_rx_state_t rx_state;
    logic [BCW-1:0] rx_cnt;
    logic [2:0]     rx_bit;
    uart_byte_t     rx_shr;
    logic           rxd_m;
    logic           rxd_s;
    uart_byte_t     fifo [FIFO_SIZ];
    logic [PTW-1:0] wr_ptr;
    logic [PTW-1:0] rd_ptr;
    logic [CNW-1:0] cnt;
    logic           ovr;

    ////////////////////////////////////////////////////////////
    // bus registers
    ////////////////////////////////////////////////////////////

    logic sel_dat, sel_sta;
    logic tx_busy, rx_ne, rx_full;
    logic tx_go, rx_pop, sta_rd;

    assign sel_dat = req.adr[OFS_W-1:0] == UART_DATA_OFS;
    assign sel_sta = req.adr[OFS_W-1:0] == UART_STAT_OFS;
    assign tx_busy = tx_state != TX_IDLE;
    assign rx_ne   = cnt != '0;
    assign rx_full = cnt == CNW'(FIFO_SIZ);
    // write while busy is dropped
    assign tx_go   = vld & req.wen & sel_dat & ~tx_busy;
    assign rx_pop  = vld & ~req.wen & sel_dat & rx_ne;
    assign sta_rd  = vld & ~req.wen & sel_sta;

    always_comb begin
        rsp = '{rdt: '0, err: 1'b0};
        if (sel_dat & req.wen) begin
            rsp.err = tx_busy;
        end else if (sel_dat) begin
            // empty fifo reads zero with error
            rsp.rdt = rx_ne ? tcb_dat_t'(fifo[rd_ptr]) : '0;
            rsp.err = ~rx_ne;
        end else if (sel_sta) begin
            rsp.rdt = tcb_dat_t'({ovr, rx_ne, tx_busy});
        end else begin
            rsp.err = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // transmitter
    ////////////////////////////////////////////////////////////

    logic tx_end;
    assign tx_end = tx_cnt == BIT_END;

    always_ff @(posedge clk) begin
        if (reset) begin
            rdy      <= 1'b0;
            tx_state <= TX_IDLE;
            tx_cnt   <= '0;
            tx_bit   <= '0;
            uart_txd <= 1'b1;
        end else begin
            rdy <= 1'b1;
            // baud counter runs only inside a frame
            if (tx_busy) tx_cnt <= tx_end ? '0 : tx_cnt + 1'b1;
            case (tx_state)
                TX_IDLE: if (tx_go) begin
                    tx_state <= TX_START;
                    uart_txd <= 1'b0;
                end
                TX_START: if (tx_end) begin
                    tx_state <= TX_DATA;
                    tx_bit   <= '0;
                    uart_txd <= tx_shr[0];
                end
                TX_DATA: if (tx_end) begin
                    tx_bit   <= tx_bit + 1'b1;
                    // after bit 7 comes the stop bit
                    uart_txd <= (tx_bit == 3'd7) | tx_shr[0];
                    if (tx_bit == 3'd7) tx_state <= TX_STOP;
                end
                TX_STOP: if (tx_end) tx_state <= TX_IDLE;
            endcase
        end
    end

    // lsb first shift register
    always_ff @(posedge clk) begin
        if (tx_go) begin
            tx_shr <= req.wdt[7:0];
        end else if (tx_end & ((tx_state == TX_START) | (tx_state == TX_DATA))) begin
            tx_shr <= tx_shr >> 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // receiver
    ////////////////////////////////////////////////////////////

    logic rx_end, rx_done;
    assign rx_end  = rx_cnt == BIT_END;
    // stop bit sampled high
    assign rx_done = (rx_state == RX_STOP) & rx_end & rxd_s;

    // line synchronizer, idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_m <= 1'b1;
            rxd_s <= 1'b1;
        end else begin
            rxd_m <= uart_rxd;
            rxd_s <= rxd_m;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_state <= RX_IDLE;
            rx_cnt   <= '0;
            rx_bit   <= '0;
        end else begin
            case (rx_state)
                // falling edge starts the count
                RX_IDLE: if (~rxd_s) begin
                    rx_state <= RX_START;
                    rx_cnt   <= '0;
                end
                // mid start bit, high again means a glitch
                RX_START: if (rx_cnt == BIT_MID) begin
                    rx_cnt   <= '0;
                    rx_bit   <= '0;
                    rx_state <= rxd_s ? RX_IDLE : RX_DATA;
                end else begin
                    rx_cnt <= rx_cnt + 1'b1;
                end
                RX_DATA: begin
                    rx_cnt <= rx_end ? '0 : rx_cnt + 1'b1;
                    if (rx_end) rx_bit <= rx_bit + 1'b1;
                    if (rx_end & (rx_bit == 3'd7)) rx_state <= RX_STOP;
                end
                RX_STOP: begin
                    rx_cnt <= rx_end ? '0 : rx_cnt + 1'b1;
                    if (rx_end) rx_state <= RX_IDLE;
                end
            endcase
        end
    end

    // mid-bit samples enter at the msb
    always_ff @(posedge clk) begin
        if ((rx_state == RX_DATA) & rx_end) rx_shr <= {rxd_s, rx_shr[7:1]};
    end

    ////////////////////////////////////////////////////////////
    // receive fifo
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rx_done & ~rx_full) fifo[wr_ptr] <= rx_shr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
            ovr    <= 1'b0;
        end else begin
            if (rx_done & ~rx_full) wr_ptr <= ptr_inc(wr_ptr);
            if (rx_pop) rd_ptr <= ptr_inc(rd_ptr);
            cnt <= cnt + CNW'(rx_done & ~rx_full) - CNW'(rx_pop);
            // full fifo drops the byte, flag cleared by status read
            if (rx_done & rx_full) begin
                ovr <= 1'b1;
            end else if (sta_rd) begin
                ovr <= 1'b0;
            end
        end
    end

endmodule
